// File: verilog/exec_defines.svh
// Widths, ALU modes, jump codes and flag positions of the execute stage
// Include in any file that uses these macros; the guard makes repeats harmless
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

`define EXEC_RW          16
`define EXEC_REGNO       8
`define EXEC_REGNO_LOG   3
`define EXEC_ALU_MODE_W  4
`define EXEC_FLAG_CNT    5
`define EXEC_JUMP_CODE_W 5

// Flag bit positions
`define EXEC_FLAG_Z 0
`define EXEC_FLAG_C 1
`define EXEC_FLAG_N 2
`define EXEC_FLAG_O 3
`define EXEC_FLAG_P 4

// ALU modes
`define EXEC_ALU_ADD    4'h0
`define EXEC_ALU_SUB    4'h1
`define EXEC_ALU_AND    4'h2
`define EXEC_ALU_OR     4'h3
`define EXEC_ALU_XOR    4'h4
`define EXEC_ALU_SHL    4'h5
`define EXEC_ALU_SHR    4'h6
`define EXEC_ALU_PASS_R 4'h7

// Jump codes, top bit set marks a jump
`define EXEC_JMP_UNCOND 5'b10000
`define EXEC_JMP_CARRY  5'b10001
`define EXEC_JMP_EQ     5'b10010
`define EXEC_JMP_LT     5'b10011
`define EXEC_JMP_GT     5'b10100
`define EXEC_JMP_LE     5'b10101
`define EXEC_JMP_GE     5'b10110
`define EXEC_JMP_NE     5'b10111
`define EXEC_JMP_OVF    5'b11000
`define EXEC_JMP_PAR    5'b11001
`define EXEC_JMP_GTU    5'b11010
`define EXEC_JMP_GEU    5'b11011
`define EXEC_JMP_LEU    5'b11100

`define EXEC_RESET_PC 16'h0000

`endif

// File: verilog/exec_pkg.sv
// Vector types shared by the execute stage RTL and its testbench
// Modules refer to these by exec_pkg:: in port lists and import it in the body
`include "exec_defines.svh"

package exec_pkg;

    // Data word, also used for addresses and the PC
    typedef logic [`EXEC_RW-1:0] word_t;

    // Index into the register file
    typedef logic [`EXEC_REGNO_LOG-1:0] reg_sel_t;

    // One bit per register, set bits are written
    typedef logic [`EXEC_REGNO-1:0] reg_mask_t;

    // Operation select for the ALU
    typedef logic [`EXEC_ALU_MODE_W-1:0] alu_mode_t;

    // Z, C, N, O and P flags, positions from the defines
    typedef logic [`EXEC_FLAG_CNT-1:0] flags_t;

    // Jump condition, top bit set means the instruction is a jump
    typedef logic [`EXEC_JUMP_CODE_W-1:0] jump_code_t;

endpackage

// File: verilog/exec_ctrl.sv
// Execute stage control: instruction validity, hold, RAW hazard stall and flush
// Produces the fire strobe that lets the datapath modules update their state
`timescale 1ns/1ns

module exec_ctrl (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_submit,
    input  logic               i_flush,
    input  logic               i_next_ready,
    input  logic [1:0]         i_used_operands,
    input  exec_pkg::reg_sel_t  i_l_reg_sel,
    input  exec_pkg::reg_sel_t  i_r_reg_sel,
    input  exec_pkg::reg_mask_t i_pending_ie,
    input  logic               i_out_submit,
    input  logic               i_redirect,
    output logic               o_ready,
    output logic               o_fire,
    output logic               o_flush
);

    logic hold_valid;
    logic next_ready_q;
    logic raw_hazard;
    logic invalidate;
    logic in_valid;
    logic instr_valid;

    // An operand is still being written by the instruction ahead of us.
    // The delayed ready covers the first cycle after the memory stage stalled
    assign raw_hazard = ((i_used_operands[0] & i_pending_ie[i_l_reg_sel]) |
                         (i_used_operands[1] & i_pending_ie[i_r_reg_sel])) &
                        (i_out_submit | ~next_ready_q);

    // Wrong-path instructions arrive while our own flush is high
    assign invalidate  = i_flush | o_flush;
    assign in_valid    = i_submit & ~invalidate;
    assign instr_valid = in_valid | (hold_valid & ~i_submit & ~invalidate);

    assign o_fire  = i_next_ready & instr_valid & ~raw_hazard;
    assign o_ready = o_fire | ~instr_valid;

    // Keep a stalled instruction alive until it fires or is flushed
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            hold_valid <= 1'b0;
        end else if (invalidate | o_fire) begin
            hold_valid <= 1'b0;
        end else if (in_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            next_ready_q <= 1'b0;
            o_flush      <= 1'b0;
        end else begin
            next_ready_q <= i_next_ready;
            // Earlier stages fetched the wrong path, drop them next cycle
            o_flush      <= i_redirect & o_fire;
        end
    end

endmodule

// File: verilog/exec_regfile.sv
// General purpose register file, eight words with two combinational read ports
// Written back from a later stage through a per-register write mask
`timescale 1ns/1ns
`include "exec_defines.svh"

module exec_regfile (
    input  logic                i_clk,
    input  logic                i_rst,
    input  exec_pkg::reg_mask_t i_ie,
    input  exec_pkg::word_t     i_d,
    input  exec_pkg::reg_sel_t  i_l_sel,
    input  exec_pkg::reg_sel_t  i_r_sel,
    output exec_pkg::word_t     o_l,
    output exec_pkg::word_t     o_r
);

    import exec_pkg::*;

    word_t regs [`EXEC_REGNO];

    // Every register whose mask bit is set takes the same write-back word
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `EXEC_REGNO; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `EXEC_REGNO; i++) begin
                if (i_ie[i]) begin
                    regs[i] <= i_d;
                end
            end
        end
    end

    // No bypass, a written value is visible one cycle after the write
    assign o_l = regs[i_l_sel];
    assign o_r = regs[i_r_sel];

endmodule

// File: verilog/exec_alu.sv
// Combinational integer ALU with carry-in
// Returns the result and the flag values the flag register may load
`timescale 1ns/1ns
`include "exec_defines.svh"

module exec_alu (
    input  exec_pkg::word_t     i_l,
    input  exec_pkg::word_t     i_r,
    input  exec_pkg::alu_mode_t i_mode,
    input  logic                i_carry,
    output exec_pkg::word_t     o_res,
    output exec_pkg::flags_t    o_flags
);

    import exec_pkg::*;

    logic [`EXEC_RW:0] sum;
    logic [`EXEC_RW:0] diff;
    word_t res;
    logic  carry;
    logic  ovf;

    assign sum  = {1'b0, i_l} + {1'b0, i_r} + {{`EXEC_RW{1'b0}}, i_carry};
    // Top bit of the difference is the borrow
    assign diff = {1'b0, i_l} - {1'b0, i_r} - {{`EXEC_RW{1'b0}}, i_carry};

    always_comb begin
        carry = 1'b0;
        ovf   = 1'b0;
        case (i_mode)
            `EXEC_ALU_ADD: begin
                res   = sum[`EXEC_RW-1:0];
                carry = sum[`EXEC_RW];
                ovf   = (i_l[`EXEC_RW-1] == i_r[`EXEC_RW-1]) &
                        (res[`EXEC_RW-1] != i_l[`EXEC_RW-1]);
            end
            `EXEC_ALU_SUB: begin
                res   = diff[`EXEC_RW-1:0];
                carry = diff[`EXEC_RW];
                ovf   = (i_l[`EXEC_RW-1] != i_r[`EXEC_RW-1]) &
                        (res[`EXEC_RW-1] != i_l[`EXEC_RW-1]);
            end
            `EXEC_ALU_AND:    res = i_l & i_r;
            `EXEC_ALU_OR:     res = i_l | i_r;
            `EXEC_ALU_XOR:    res = i_l ^ i_r;
            // Shift amount is the low nibble of the right operand
            `EXEC_ALU_SHL:    res = i_l << i_r[3:0];
            `EXEC_ALU_SHR:    res = i_l >> i_r[3:0];
            `EXEC_ALU_PASS_R: res = i_r;
            default:          res = '0;
        endcase
    end

    assign o_res = res;

    always_comb begin
        o_flags              = '0;
        o_flags[`EXEC_FLAG_Z] = (res == '0);
        o_flags[`EXEC_FLAG_C] = carry;
        o_flags[`EXEC_FLAG_N] = res[`EXEC_RW-1];
        o_flags[`EXEC_FLAG_O] = ovf;
        o_flags[`EXEC_FLAG_P] = ^res;
    end

endmodule

// File: verilog/exec_branch.sv
// Flag register, jump condition decode and program counter
// Redirect tells control that fetch's sequential guess was wrong
`timescale 1ns/1ns
`include "exec_defines.svh"

module exec_branch (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_fire,
    input  exec_pkg::jump_code_t i_jump_code,
    input  logic                 i_jmp_predict,
    input  logic                 i_pc_inc,
    input  logic                 i_pc_ie,
    input  exec_pkg::flags_t     i_flags_d,
    input  logic                 i_flags_ie,
    input  logic                 i_carry_en,
    input  exec_pkg::word_t      i_target,
    output exec_pkg::word_t      o_pc,
    output logic                 o_carry,
    output logic                 o_redirect
);

    import exec_pkg::*;

    flags_t flags_q;
    word_t  pc_q;
    logic   is_jump;
    logic   taken;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags_q <= '0;
        end else if (i_fire & i_flags_ie) begin
            flags_q <= i_flags_d;
        end
    end

    assign is_jump = i_jump_code[`EXEC_JUMP_CODE_W-1];

    // Conditions look at the flags left by earlier instructions
    always_comb begin
        case (i_jump_code)
            `EXEC_JMP_UNCOND: taken = 1'b1;
            `EXEC_JMP_CARRY:  taken = flags_q[`EXEC_FLAG_C];
            `EXEC_JMP_EQ:     taken = flags_q[`EXEC_FLAG_Z];
            `EXEC_JMP_LT:     taken = flags_q[`EXEC_FLAG_N];
            `EXEC_JMP_GT:     taken = ~(flags_q[`EXEC_FLAG_N] | flags_q[`EXEC_FLAG_Z]);
            `EXEC_JMP_LE:     taken = flags_q[`EXEC_FLAG_N] | flags_q[`EXEC_FLAG_Z];
            `EXEC_JMP_GE:     taken = ~flags_q[`EXEC_FLAG_N];
            `EXEC_JMP_NE:     taken = ~flags_q[`EXEC_FLAG_Z];
            `EXEC_JMP_OVF:    taken = flags_q[`EXEC_FLAG_O];
            `EXEC_JMP_PAR:    taken = flags_q[`EXEC_FLAG_P];
            `EXEC_JMP_GTU:    taken = ~(flags_q[`EXEC_FLAG_C] | flags_q[`EXEC_FLAG_Z]);
            `EXEC_JMP_GEU:    taken = ~flags_q[`EXEC_FLAG_C];
            `EXEC_JMP_LEU:    taken = flags_q[`EXEC_FLAG_C] | flags_q[`EXEC_FLAG_Z];
            default:          taken = 1'b0;
        endcase
    end

    // Load has priority over increment
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= `EXEC_RESET_PC;
        end else if (i_fire) begin
            if (i_pc_ie | (is_jump & taken)) begin
                pc_q <= i_target;
            end else if (i_pc_inc | (is_jump & ~taken)) begin
                pc_q <= pc_q + 1'b1;
            end
        end
    end

    assign o_pc       = pc_q;
    assign o_carry    = flags_q[`EXEC_FLAG_C] & i_carry_en;
    assign o_redirect = (is_jump & (taken ^ i_jmp_predict)) | i_pc_ie;

endmodule

// File: verilog/exec_out_reg.sv
// Registered hand-off toward the memory stage
// Loads on fire; o_submit is a one-cycle strobe marking new contents
`timescale 1ns/1ns
`include "exec_defines.svh"

module exec_out_reg (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_fire,
    input  exec_pkg::word_t     i_alu_res,
    input  exec_pkg::word_t     i_r_data,
    input  exec_pkg::word_t     i_pc,
    input  logic                i_mem_access,
    input  logic                i_mem_we,
    input  logic                i_mem_width,
    input  logic                i_link,
    input  exec_pkg::reg_mask_t i_rf_ie,
    output exec_pkg::word_t     o_addr,
    output exec_pkg::word_t     o_data,
    output exec_pkg::reg_mask_t o_reg_ie,
    output logic                o_mem_access,
    output logic                o_mem_we,
    output logic                o_mem_width,
    output logic                o_submit
);

    // Payload, only meaningful while o_submit is high
    always_ff @(posedge i_clk) begin
        if (i_fire) begin
            o_addr       <= i_alu_res;
            o_mem_access <= i_mem_access;
            o_mem_we     <= i_mem_we;
            o_mem_width  <= i_mem_width;
            // Store data, return address, or plain result
            if (i_mem_access) begin
                o_data <= i_r_data;
            end else if (i_link) begin
                o_data <= i_pc + `EXEC_RW'(1);
            end else begin
                o_data <= i_alu_res;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst | ~i_fire) begin
            o_submit <= 1'b0;
            o_reg_ie <= '0;
        end else begin
            o_submit <= 1'b1;
            o_reg_ie <= i_rf_ie;
        end
    end

endmodule

// File: verilog/exec_stage.sv
// Execute stage of the 16-bit pipelined core
// Takes decoded control from the decode stage and hands results to the memory stage
`timescale 1ns/1ns

module exec_stage (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_submit,
    input  logic                 i_flush,
    input  exec_pkg::word_t      i_imm,
    input  logic                 i_jmp_predict,
    input  logic                 i_pc_inc,
    input  logic                 i_pc_ie,
    input  logic                 i_r_bus_imm,
    input  exec_pkg::alu_mode_t  i_alu_mode,
    input  logic                 i_carry_en,
    input  logic                 i_flags_ie,
    input  exec_pkg::reg_sel_t   i_l_reg_sel,
    input  exec_pkg::reg_sel_t   i_r_reg_sel,
    input  exec_pkg::reg_mask_t  i_rf_ie,
    input  exec_pkg::jump_code_t i_jump_code,
    input  logic                 i_mem_access,
    input  logic                 i_mem_we,
    input  logic                 i_mem_width,
    input  logic [1:0]           i_used_operands,
    input  logic                 i_link,
    input  logic                 i_next_ready,
    input  exec_pkg::reg_mask_t  i_reg_ie,
    input  exec_pkg::word_t      i_reg_data,
    output logic                 o_ready,
    output logic                 o_flush,
    output logic                 o_pc_update,
    output exec_pkg::word_t      o_exec_pc,
    output exec_pkg::word_t      o_data,
    output exec_pkg::word_t      o_addr,
    output exec_pkg::reg_mask_t  o_reg_ie,
    output logic                 o_mem_access,
    output logic                 o_mem_we,
    output logic                 o_mem_width,
    output logic                 o_submit
);

    import exec_pkg::*;

    logic   exec_fire;
    logic   redirect;
    logic   alu_carry;
    word_t  rf_l;
    word_t  rf_r;
    word_t  alu_r;
    word_t  alu_res;
    flags_t alu_flags;

    // Right operand is either a register or the immediate
    assign alu_r       = i_r_bus_imm ? i_imm : rf_r;
    assign o_pc_update = exec_fire;

    exec_ctrl u_ctrl (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_submit(i_submit), .i_flush(i_flush), .i_next_ready(i_next_ready),
        .i_used_operands(i_used_operands),
        .i_l_reg_sel(i_l_reg_sel), .i_r_reg_sel(i_r_reg_sel),
        .i_pending_ie(o_reg_ie), .i_out_submit(o_submit), .i_redirect(redirect),
        .o_ready(o_ready), .o_fire(exec_fire), .o_flush(o_flush)
    );

    exec_regfile u_regfile (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_ie(i_reg_ie), .i_d(i_reg_data),
        .i_l_sel(i_l_reg_sel), .i_r_sel(i_r_reg_sel),
        .o_l(rf_l), .o_r(rf_r)
    );

    exec_alu u_alu (
        .i_l(rf_l), .i_r(alu_r), .i_mode(i_alu_mode), .i_carry(alu_carry),
        .o_res(alu_res), .o_flags(alu_flags)
    );

    exec_branch u_branch (
        .i_clk(i_clk), .i_rst(i_rst), .i_fire(exec_fire),
        .i_jump_code(i_jump_code), .i_jmp_predict(i_jmp_predict),
        .i_pc_inc(i_pc_inc), .i_pc_ie(i_pc_ie),
        .i_flags_d(alu_flags), .i_flags_ie(i_flags_ie), .i_carry_en(i_carry_en),
        .i_target(alu_res),
        .o_pc(o_exec_pc), .o_carry(alu_carry), .o_redirect(redirect)
    );

    // Link value is taken from the PC before this instruction updates it
    exec_out_reg u_out_reg (
        .i_clk(i_clk), .i_rst(i_rst), .i_fire(exec_fire),
        .i_alu_res(alu_res), .i_r_data(rf_r), .i_pc(o_exec_pc),
        .i_mem_access(i_mem_access), .i_mem_we(i_mem_we), .i_mem_width(i_mem_width),
        .i_link(i_link), .i_rf_ie(i_rf_ie),
        .o_addr(o_addr), .o_data(o_data), .o_reg_ie(o_reg_ie),
        .o_mem_access(o_mem_access), .o_mem_we(o_mem_we), .o_mem_width(o_mem_width),
        .o_submit(o_submit)
    );

endmodule

// File: sim/tb_exec_stage.sv
// Directed testbench for the execute stage
// Issues instructions through the submit/ready handshake and checks the memory-stage side
`timescale 1ns/1ns
`include "exec_defines.svh"

module tb_exec_stage;

    import exec_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int TIMEOUT    = 40;
    localparam int SEED       = 24;

    logic       i_clk = 1'b0;
    logic       i_rst, i_submit, i_flush, i_jmp_predict, i_pc_inc, i_pc_ie, i_r_bus_imm;
    logic       i_carry_en, i_flags_ie, i_mem_access, i_mem_we, i_mem_width, i_link;
    logic       i_next_ready, o_ready, o_flush, o_pc_update, o_mem_access, o_mem_we;
    logic       o_mem_width, o_submit;
    logic [1:0] i_used_operands;
    word_t      i_imm, i_reg_data, o_exec_pc, o_data, o_addr;
    alu_mode_t  i_alu_mode;
    reg_sel_t   i_l_reg_sel, i_r_reg_sel;
    reg_mask_t  i_rf_ie, i_reg_ie, o_reg_ie;
    jump_code_t i_jump_code;

    // Register contents as written back by the testbench
    word_t      regs [`EXEC_REGNO];
    word_t      pc_at_fire;
    string      test_name;

    exec_stage i_dut (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // Expected ALU result, carry-in held at zero
    function automatic word_t alu_expect(alu_mode_t mode, word_t l, word_t r);
        case (mode)
            `EXEC_ALU_ADD: return l + r;
            `EXEC_ALU_SUB: return l - r;
            `EXEC_ALU_AND: return l & r;
            `EXEC_ALU_OR:  return l | r;
            `EXEC_ALU_XOR: return l ^ r;
            `EXEC_ALU_SHL: return l << r[3:0];
            `EXEC_ALU_SHR: return l >> r[3:0];
            default:       return r;
        endcase
    endfunction

    // Jump outcome after a compare of l against r
    function automatic logic jump_expect(jump_code_t code, word_t l, word_t r);
        word_t d;
        logic  neg;
        int    sd;
        d   = l - r;
        neg = d[`EXEC_RW-1];
        // Exact signed difference, overflow when it leaves the 16-bit range
        sd  = int'($signed(l)) - int'($signed(r));
        case (code)
            `EXEC_JMP_UNCOND: return 1'b1;
            `EXEC_JMP_CARRY:  return l < r;
            `EXEC_JMP_EQ:     return l == r;
            `EXEC_JMP_LT:     return neg;
            `EXEC_JMP_GT:     return !neg && (l != r);
            `EXEC_JMP_LE:     return neg || (l == r);
            `EXEC_JMP_GE:     return !neg;
            `EXEC_JMP_NE:     return l != r;
            `EXEC_JMP_OVF:    return (sd > 32767) || (sd < -32768);
            `EXEC_JMP_PAR:    return ^d;
            `EXEC_JMP_GTU:    return l > r;
            `EXEC_JMP_GEU:    return l >= r;
            default:          return l <= r;
        endcase
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(string what, word_t exp, word_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_mask(string what, reg_mask_t exp, reg_mask_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
        end
    endtask

    // Inputs change a little after the rising edge
    task automatic next_slot();
        @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    task automatic clear_instr();
        {i_submit, i_flush, i_jmp_predict, i_pc_inc, i_pc_ie, i_r_bus_imm, i_carry_en} = '0;
        {i_flags_ie, i_mem_access, i_mem_we, i_mem_width, i_link, i_used_operands} = '0;
        {i_imm, i_alu_mode, i_l_reg_sel, i_r_reg_sel, i_rf_ie, i_jump_code} = '0;
    endtask

    // Write-back port, the value is readable from the next cycle on
    task automatic load_reg(int idx, word_t val);
        i_reg_ie   = reg_mask_t'(1 << idx);
        i_reg_data = val;
        regs[idx]  = val;
        next_slot();
        i_reg_ie   = '0;
    endtask

    // Hold the instruction until it fires, then release the inputs
    task automatic issue();
        int cycles;
        cycles   = 0;
        i_submit = 1'b1;
        do begin
            @(negedge i_clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("Timeout in %s, the stage never became ready", test_name));
            end
        end while (!o_ready);
        check_bit("o_pc_update", 1'b1, o_pc_update);
        pc_at_fire = o_exec_pc;
        next_slot();
        clear_instr();
    endtask

    task automatic expect_out(word_t addr, word_t data, reg_mask_t mask, logic flush);
        int cycles;
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("Timeout in %s, no result reached the memory stage",
                                    test_name));
            end
        end while (!o_submit);
        check_word("o_addr", addr, o_addr);
        check_word("o_data", data, o_data);
        check_mask("o_reg_ie", mask, o_reg_ie);
        check_bit("o_flush", flush, o_flush);
    endtask

    task automatic test_reset();
        test_name = "reset";
        @(negedge i_clk);
        check_bit("o_submit", 1'b0, o_submit);
        check_bit("o_flush", 1'b0, o_flush);
        check_mask("o_reg_ie", '0, o_reg_ie);
        check_word("o_exec_pc", `EXEC_RESET_PC, o_exec_pc);
        next_slot();
    endtask

    task automatic test_alu();
        reg_mask_t mask;
        word_t     res;
        repeat (3) begin
            load_reg(1, word_t'($urandom));
            load_reg(2, word_t'($urandom));
            for (int m = 0; m < 8; m++) begin
                test_name       = $sformatf("alu mode %0d", m);
                mask            = reg_mask_t'($urandom);
                res             = alu_expect(alu_mode_t'(m), regs[1], regs[2]);
                i_alu_mode      = alu_mode_t'(m);
                i_l_reg_sel     = 3'd1;
                i_r_reg_sel     = 3'd2;
                i_used_operands = 2'b11;
                i_rf_ie         = mask;
                issue();
                expect_out(res, res, mask, 1'b0);
                next_slot();
            end
        end
    endtask

    task automatic test_jumps();
        word_t      l;
        word_t      r;
        word_t      target;
        jump_code_t code;
        logic       predict;
        logic       taken;
        for (int p = 0; p < 3; p++) begin
            l = word_t'($urandom);
            r = (p == 1) ? l : word_t'($urandom);
            load_reg(5, l);
            load_reg(6, r);
            for (int c = 0; c < 13; c++) begin
                code      = jump_code_t'(`EXEC_JMP_UNCOND + c);
                test_name = $sformatf("jump %b", code);
                // Compare first, it leaves the flags the jump decodes
                i_alu_mode      = `EXEC_ALU_SUB;
                i_l_reg_sel     = 3'd5;
                i_r_reg_sel     = 3'd6;
                i_used_operands = 2'b11;
                i_flags_ie      = 1'b1;
                issue();
                next_slot();
                target        = word_t'($urandom);
                predict       = 1'($urandom);
                taken         = jump_expect(code, l, r);
                i_alu_mode    = `EXEC_ALU_PASS_R;
                i_r_bus_imm   = 1'b1;
                i_imm         = target;
                i_jump_code   = code;
                i_jmp_predict = predict;
                issue();
                expect_out(target, target, '0, taken != predict);
                check_word("o_exec_pc", taken ? target : pc_at_fire + 16'd1, o_exec_pc);
                next_slot();
            end
        end
    endtask

    task automatic test_mem_link();
        word_t off;
        off       = word_t'($urandom);
        test_name = "store";
        load_reg(3, word_t'($urandom));
        load_reg(4, word_t'($urandom));
        i_l_reg_sel     = 3'd3;
        i_r_reg_sel     = 3'd4;
        i_r_bus_imm     = 1'b1;
        i_imm           = off;
        i_used_operands = 2'b11;
        i_mem_access    = 1'b1;
        i_mem_we        = 1'b1;
        i_mem_width     = 1'b1;
        issue();
        expect_out(regs[3] + off, regs[4], '0, 1'b0);
        check_bit("o_mem_access", 1'b1, o_mem_access);
        check_bit("o_mem_we", 1'b1, o_mem_we);
        check_bit("o_mem_width", 1'b1, o_mem_width);
        next_slot();
        // Jump and link, return address is the PC after this instruction
        test_name     = "link";
        i_alu_mode    = `EXEC_ALU_PASS_R;
        i_r_bus_imm   = 1'b1;
        i_imm         = off;
        i_jump_code   = `EXEC_JMP_UNCOND;
        i_jmp_predict = 1'b1;
        i_link        = 1'b1;
        i_rf_ie       = 8'h80;
        issue();
        expect_out(off, pc_at_fire + 16'd1, 8'h80, 1'b0);
        check_word("o_exec_pc", off, o_exec_pc);
        next_slot();
    endtask

    task automatic test_stall();
        word_t sum;
        test_name       = "stall";
        sum             = regs[1] + regs[2];
        i_next_ready    = 1'b0;
        i_l_reg_sel     = 3'd1;
        i_r_reg_sel     = 3'd2;
        i_used_operands = 2'b11;
        i_rf_ie         = 8'h08;
        i_submit        = 1'b1;
        repeat (4) begin
            @(negedge i_clk);
            check_bit("o_ready", 1'b0, o_ready);
            check_bit("o_pc_update", 1'b0, o_pc_update);
            check_bit("o_submit", 1'b0, o_submit);
        end
        next_slot();
        i_next_ready = 1'b1;
        issue();
        // Next instruction reads r3 while its new value is still in flight
        i_alu_mode      = `EXEC_ALU_SUB;
        i_l_reg_sel     = 3'd3;
        i_r_reg_sel     = 3'd1;
        i_used_operands = 2'b01;
        i_submit        = 1'b1;
        expect_out(sum, sum, 8'h08, 1'b0);
        test_name = "hazard";
        check_bit("o_ready", 1'b0, o_ready);
        check_bit("o_pc_update", 1'b0, o_pc_update);
        issue();
        expect_out(regs[3] - regs[1], regs[3] - regs[1], '0, 1'b0);
        next_slot();
    endtask

    initial begin
        void'($urandom(SEED));
        i_rst        = 1'b1;
        i_next_ready = 1'b1;
        i_reg_ie     = '0;
        i_reg_data   = '0;
        clear_instr();
        repeat (8) @(posedge i_clk);
        #DRIVE_DLY;
        i_rst = 1'b0;
        test_reset();
        test_alu();
        test_jumps();
        test_mem_link();
        test_stall();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/exec_ctrl.sv
verilog/exec_regfile.sv
verilog/exec_alu.sv
verilog/exec_branch.sv
verilog/exec_out_reg.sv
verilog/exec_stage.sv
sim/tb_exec_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal -f filelist.f --top-module tb_exec_stage -o tb_exec_stage \
    && ./obj_dir/tb_exec_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log 2>/dev/null && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
